// ==== files.f ====
hw/huf_sym_pkg.sv
hw/huf_ctl_pkg.sv
hw/huf_comp_sm.sv
hw/huf_comp_sq.sv
hw/huf_comp_lut.sv
hw/huf_comp_sa.sv
hw/huf_comp_sc.sv
hw/huf_comp_core.sv
bench/tb_huf_comp_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the Huffman encode core testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_huf_comp_core \
   -f files.f -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
   exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== bench/tb_huf_comp_core.sv ====
// Testbench of the Huffman encode core.
// Loads code tables, streams symbol blocks from a case table and checks
// the packed words and block statistics against a reference packer.
// Ends with a sticky memory error check.

module tb_huf_comp_core;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_CASES = 4;
   localparam int MAX_SYMS  = 12;
   localparam int TMO       = 200;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  in_valid;
   huf_sym_pkg::sym_t     in_sym;
   logic                  in_last;
   logic                  out_ready;
   logic                  lut_wr;
   huf_sym_pkg::sym_t     lut_addr;
   huf_sym_pkg::code_t    lut_code;
   huf_sym_pkg::len_t     lut_len;
   logic                  ecc_error;
   logic                  in_ready;
   logic                  out_valid;
   huf_sym_pkg::word_t    out_data;
   huf_sym_pkg::nbits_t   out_nbits;
   logic                  out_last;
   logic                  blk_done;
   huf_ctl_pkg::sym_cnt_t blk_sym_cnt;
   huf_ctl_pkg::bit_cnt_t blk_bit_cnt;
   logic                  ecc_error_reg;

   // **********************************************************************
   // case table of code set, random ready, symbol count and symbols
   // **********************************************************************
   int case_set  [NUM_CASES] = '{0, 0, 0, 1};
   bit case_rand [NUM_CASES] = '{1'b0, 1'b0, 1'b1, 1'b1};
   int case_nsym [NUM_CASES] = '{12, 3, 12, 12};
   int case_syms [NUM_CASES][MAX_SYMS] = '{
      '{0, 5, 11, 3, 9, 10, 1, 7, 11, 2, 6, 4},
      // 12 + 12 + 8 bits end on a word boundary.
      '{11, 11, 7, 0, 0, 0, 0, 0, 0, 0, 0, 0},
      '{4, 8, 11, 10, 6, 2, 11, 9, 3, 15, 14, 12},
      '{0, 5, 11, 3, 9, 10, 1, 7, 11, 2, 6, 4}
   };

   logic [31:0] exp_data  [$];
   int          exp_nbits [$];
   bit          exp_last  [$];
   int          exp_sym_cnt;
   int          exp_bit_cnt;
   int          mismatch_cnt = 0;
   int          fail_cnt = 0;
   bit          rand_ready = 1'b0;
   logic [31:0] rng = 32'd7;

   huf_comp_core #(.SQ_DEPTH(8)) huf_comp_core_inst (.*);

   always #20 clk = ~clk;

   always @(posedge clk) begin
      #2;
      if (rand_ready) begin
         rng = xorshift32(rng);
         out_ready = rng[3];
      end else begin
         out_ready = 1'b1;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // two table sets; high bits above the length are don't care.
   function automatic int len_of(input int set, input int sym);
      return (set == 0) ? (sym % 12) + 1 : 12 - (sym % 12);
   endfunction

   function automatic logic [11:0] code_of(input int set, input int sym);
      return (set == 0) ? 12'(sym * 'h2F1 + 'h5A3) : 12'((sym * 'h1B7) ^ 'hC3C);
   endfunction

   // MSB-first packing from bit 31 down with the last block word flushed.
   function void pack_reference(input int c);
      logic [31:0] word;
      logic [11:0] code;
      int          n;
      int          len;
      int          sym;
      exp_data.delete();
      exp_nbits.delete();
      exp_last.delete();
      exp_sym_cnt = case_nsym[c];
      exp_bit_cnt = 0;
      word = '0;
      n = 0;
      for (int i = 0; i < case_nsym[c]; i++) begin
         sym = case_syms[c][i];
         len = len_of(case_set[c], sym);
         code = code_of(case_set[c], sym);
         exp_bit_cnt += len;
         for (int b = len - 1; b >= 0; b--) begin
            word[31 - n] = code[b];
            n++;
            if (n == 32) begin
               exp_data.push_back(word);
               exp_nbits.push_back(32);
               exp_last.push_back((i == case_nsym[c] - 1) && (b == 0));
               word = '0;
               n = 0;
            end
         end
      end
      if (n > 0) begin
         exp_data.push_back(word);
         exp_nbits.push_back(n);
         exp_last.push_back(1'b1);
      end
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got === exp) else begin
         mismatch_cnt++;
         $display("Mismatch at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string msg);
      fail_cnt++;
      $display("Error at %0d ns: %s", $time, msg);
   endtask

   task automatic load_table(input int set);
      for (int s = 0; s < 16; s++) begin
         @(posedge clk);
         #2;
         lut_wr = 1'b1;
         lut_addr = huf_sym_pkg::sym_t'(s);
         lut_code = code_of(set, s);
         lut_len = huf_sym_pkg::len_t'(len_of(set, s));
      end
      @(posedge clk);
      #2;
      lut_wr = 1'b0;
   endtask

   task automatic send_block(input int c);
      int waited;
      for (int i = 0; i < case_nsym[c]; i++) begin
         @(posedge clk);
         #2;
         in_valid = 1'b1;
         in_sym = huf_sym_pkg::sym_t'(case_syms[c][i]);
         in_last = (i == case_nsym[c] - 1);
         waited = 0;
         @(negedge clk);
         while (!in_ready && waited < TMO) begin
            @(negedge clk);
            waited++;
         end
         assert (in_ready) else report_failure("timeout waiting for in_ready");
      end
      @(posedge clk);
      #2;
      in_valid = 1'b0;
      in_last = 1'b0;
   endtask

   task automatic collect_words();
      logic [31:0] held_data;
      logic [5:0]  held_nbits;
      logic        held_last;
      bit          held_vld;
      int          idx;
      int          waited;
      idx = 0;
      waited = 0;
      held_vld = 1'b0;
      while (idx < exp_data.size() && waited < TMO) begin
         @(negedge clk);
         // no block statistics while the block is still leaving.
         compare_value("blk_done", 32'(blk_done), 32'd0);
         if (held_vld) begin
            assert (out_valid) else report_failure("out_valid dropped without a transfer");
            compare_value("held out_data", out_data, held_data);
            compare_value("held out_nbits", 32'(out_nbits), 32'(held_nbits));
            compare_value("held out_last", 32'(out_last), 32'(held_last));
         end
         held_vld = out_valid && !out_ready;
         held_data = out_data;
         held_nbits = out_nbits;
         held_last = out_last;
         if (out_valid && out_ready) begin
            compare_value("out_data", out_data, exp_data[idx]);
            compare_value("out_nbits", 32'(out_nbits), 32'(exp_nbits[idx]));
            compare_value("out_last", 32'(out_last), 32'(exp_last[idx]));
            idx++;
            waited = 0;
         end else begin
            waited++;
         end
      end
      assert (idx == exp_data.size()) else report_failure("timeout waiting for output words");
      waited = 0;
      while (!blk_done && waited < TMO) begin
         @(negedge clk);
         waited++;
      end
      assert (blk_done) else report_failure("blk_done did not pulse after the last word");
      assert (waited == 1) else report_failure("blk_done did not follow the last word by one cycle");
      compare_value("blk_sym_cnt", 32'(blk_sym_cnt), 32'(exp_sym_cnt));
      compare_value("blk_bit_cnt", 32'(blk_bit_cnt), 32'(exp_bit_cnt));
      @(negedge clk);
      compare_value("blk_done", 32'(blk_done), 32'd0);
   endtask

   initial begin
      int loaded_set;
      rst_n = 1'b0;
      in_valid = 1'b0;
      in_sym = '0;
      in_last = 1'b0;
      out_ready = 1'b1;
      lut_wr = 1'b0;
      lut_addr = '0;
      lut_code = '0;
      lut_len = '0;
      ecc_error = 1'b0;
      loaded_set = -1;
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(negedge clk);
      compare_value("in_ready", 32'(in_ready), 32'd1);
      compare_value("out_valid", 32'(out_valid), 32'd0);
      compare_value("ecc_error_reg", 32'(ecc_error_reg), 32'd0);

      for (int c = 0; c < NUM_CASES; c++) begin
         if (case_set[c] != loaded_set) begin
            load_table(case_set[c]);
            loaded_set = case_set[c];
         end
         rand_ready = case_rand[c];
         pack_reference(c);
         fork
            send_block(c);
            collect_words();
         join
      end

      // **********************************************************************
      // sticky memory error
      // **********************************************************************
      rand_ready = 1'b0;
      @(posedge clk);
      #2;
      ecc_error = 1'b1;
      @(posedge clk);
      #2;
      ecc_error = 1'b0;
      in_valid = 1'b1;
      in_last = 1'b1;
      repeat (20) begin
         @(negedge clk);
         compare_value("ecc_error_reg", 32'(ecc_error_reg), 32'd1);
         compare_value("in_ready", 32'(in_ready), 32'd0);
         compare_value("out_valid", 32'(out_valid), 32'd0);
      end

      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== hw/huf_comp_core.sv ====
// Top level of the Huffman encode core.
// Symbols enter through a valid/ready stream, are queued, coded from a
// software-loaded table and leave as packed 32-bit words. Block
// statistics and a sticky memory error flag are reported alongside.

module huf_comp_core #(
   parameter int unsigned SQ_DEPTH = 8
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  in_valid,
   input  huf_sym_pkg::sym_t     in_sym,
   input  logic                  in_last,
   input  logic                  out_ready,
   input  logic                  lut_wr,
   input  huf_sym_pkg::sym_t     lut_addr,
   input  huf_sym_pkg::code_t    lut_code,
   input  huf_sym_pkg::len_t     lut_len,
   input  logic                  ecc_error,
   output logic                  in_ready,
   output logic                  out_valid,
   output huf_sym_pkg::word_t    out_data,
   output huf_sym_pkg::nbits_t   out_nbits,
   output logic                  out_last,
   output logic                  blk_done,
   output huf_ctl_pkg::sym_cnt_t blk_sym_cnt,
   output huf_ctl_pkg::bit_cnt_t blk_bit_cnt,
   output logic                  ecc_error_reg
);

   logic               sq_push;
   huf_sym_pkg::sym_t  sq_sym;
   logic               sq_last;
   logic               sq_full;
   logic               sq_empty;
   huf_sym_pkg::sym_t  sq_head_sym;
   logic               sq_head_last;
   logic               sq_pop;
   logic               lut_rd;
   huf_sym_pkg::sym_t  lut_rd_sym;
   huf_sym_pkg::code_t rd_code;
   huf_sym_pkg::len_t  rd_len;
   logic               sym_done;
   huf_sym_pkg::len_t  sym_len;
   logic               blk_end;

   huf_comp_sm #(.SQ_DEPTH(SQ_DEPTH)) huf_comp_sm_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_valid      (in_valid),
      .in_sym        (in_sym),
      .in_last       (in_last),
      .sq_full       (sq_full),
      .ecc_error     (ecc_error),
      .in_ready      (in_ready),
      .sq_push       (sq_push),
      .sq_sym        (sq_sym),
      .sq_last       (sq_last),
      .ecc_error_reg (ecc_error_reg)
   );

   huf_comp_sq #(.SQ_DEPTH(SQ_DEPTH)) huf_comp_sq_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .sq_push      (sq_push),
      .sq_sym       (sq_sym),
      .sq_last      (sq_last),
      .sq_pop       (sq_pop),
      .sq_full      (sq_full),
      .sq_empty     (sq_empty),
      .sq_head_sym  (sq_head_sym),
      .sq_head_last (sq_head_last)
   );

   huf_comp_lut huf_comp_lut_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .lut_wr     (lut_wr),
      .lut_addr   (lut_addr),
      .lut_code   (lut_code),
      .lut_len    (lut_len),
      .lut_rd     (lut_rd),
      .lut_rd_sym (lut_rd_sym),
      .rd_code    (rd_code),
      .rd_len     (rd_len)
   );

   huf_comp_sa huf_comp_sa_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .sq_empty     (sq_empty),
      .sq_head_sym  (sq_head_sym),
      .sq_head_last (sq_head_last),
      .rd_code      (rd_code),
      .rd_len       (rd_len),
      .out_ready    (out_ready),
      .sq_pop       (sq_pop),
      .lut_rd       (lut_rd),
      .lut_rd_sym   (lut_rd_sym),
      .out_valid    (out_valid),
      .out_data     (out_data),
      .out_nbits    (out_nbits),
      .out_last     (out_last),
      .sym_done     (sym_done),
      .sym_len      (sym_len),
      .blk_end      (blk_end)
   );

   huf_comp_sc huf_comp_sc_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .sym_done    (sym_done),
      .sym_len     (sym_len),
      .blk_end     (blk_end),
      .blk_done    (blk_done),
      .blk_sym_cnt (blk_sym_cnt),
      .blk_bit_cnt (blk_bit_cnt)
   );

endmodule

// ==== hw/huf_comp_sc.sv ====
// Per-block statistics of the Huffman encode path.
// Counts the symbols and code bits of the running block and publishes
// them with a one-cycle blk_done after the block's last word leaves.

module huf_comp_sc (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  sym_done,
   input  huf_sym_pkg::len_t     sym_len,
   input  logic                  blk_end,
   output logic                  blk_done,
   output huf_ctl_pkg::sym_cnt_t blk_sym_cnt,
   output huf_ctl_pkg::bit_cnt_t blk_bit_cnt
);

   huf_ctl_pkg::sym_cnt_t run_sym;
   huf_ctl_pkg::bit_cnt_t run_bit;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         blk_done    <= 1'b0;
         blk_sym_cnt <= '0;
         blk_bit_cnt <= '0;
         run_sym     <= '0;
         run_bit     <= '0;
      end else begin
         blk_done <= blk_end;
         if (blk_end) begin
            blk_sym_cnt <= run_sym;
            blk_bit_cnt <= run_bit;
            // a code appended now already belongs to the next block.
            if (sym_done) begin
               run_sym <= huf_ctl_pkg::sym_cnt_t'(1);
               run_bit <= huf_ctl_pkg::bit_cnt_t'(sym_len);
            end else begin
               run_sym <= '0;
               run_bit <= '0;
            end
         end else if (sym_done) begin
            run_sym <= run_sym + huf_ctl_pkg::sym_cnt_t'(1);
            run_bit <= run_bit + huf_ctl_pkg::bit_cnt_t'(sym_len);
         end
      end
   end

endmodule

// ==== hw/huf_comp_sa.sv ====
// Symbol assembler of the Huffman encode path.
// Pops symbols from the queue, looks their codes up in the table and
// packs them MSB-first into output words. A block's last code closes
// the word, so every block starts in a fresh word.

module huf_comp_sa (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                sq_empty,
   input  huf_sym_pkg::sym_t   sq_head_sym,
   input  logic                sq_head_last,
   input  huf_sym_pkg::code_t  rd_code,
   input  huf_sym_pkg::len_t   rd_len,
   input  logic                out_ready,
   output logic                sq_pop,
   output logic                lut_rd,
   output huf_sym_pkg::sym_t   lut_rd_sym,
   output logic                out_valid,
   output huf_sym_pkg::word_t  out_data,
   output huf_sym_pkg::nbits_t out_nbits,
   output logic                out_last,
   output logic                sym_done,
   output huf_sym_pkg::len_t   sym_len,
   output logic                blk_end
);

   localparam int unsigned WORD_W  = huf_sym_pkg::WORD_W;
   localparam int unsigned ACC_W   = 2 * WORD_W;
   localparam int unsigned SHIFT_W = $clog2(ACC_W) + 1;

   logic                lk_vld;
   logic                lk_last;
   huf_sym_pkg::word_t  acc;
   huf_sym_pkg::nbits_t acc_n;
   logic                flush_pend;
   logic                out_free;
   logic                append;
   logic                word_full;
   logic                flush_now;
   huf_sym_pkg::code_t  code_mask;
   huf_sym_pkg::nbits_t total;
   logic [SHIFT_W-1:0]  shift;
   logic [ACC_W-1:0]    wide;

   // **********************************************************************
   // lookup and handshake
   // **********************************************************************

   // output register is free after this edge.
   assign out_free  = !out_valid || out_ready;
   assign flush_now = flush_pend && out_free;
   assign append    = lk_vld && out_free && !flush_pend;

   // a held lookup blocks the next table read.
   assign sq_pop     = !sq_empty && (!lk_vld || append);
   assign lut_rd     = sq_pop;
   assign lut_rd_sym = sq_head_sym;

   assign sym_done = append;
   assign sym_len  = rd_len;
   assign blk_end  = out_valid && out_ready && out_last;

   // **********************************************************************
   // bit packing
   // **********************************************************************

   always_comb begin
      code_mask = ~(huf_sym_pkg::code_t'('1) << rd_len);
      total     = acc_n + huf_sym_pkg::nbits_t'(rd_len);
      shift     = SHIFT_W'(ACC_W) - SHIFT_W'(total);
      // new code lands right below the used bits.
      wide      = {acc, {WORD_W{1'b0}}} | (ACC_W'(rd_code & code_mask) << shift);
      word_full = total >= huf_sym_pkg::nbits_t'(WORD_W);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lk_vld     <= 1'b0;
         flush_pend <= 1'b0;
         out_valid  <= 1'b0;
         acc        <= '0;
         acc_n      <= '0;
      end else begin
         if (sq_pop) begin
            lk_vld <= 1'b1;
         end else if (append) begin
            lk_vld <= 1'b0;
         end
         if (out_valid && out_ready) begin
            out_valid <= 1'b0;
         end
         if (flush_now) begin
            out_valid  <= 1'b1;
            flush_pend <= 1'b0;
            acc        <= '0;
            acc_n      <= '0;
         end else if (append) begin
            if (word_full) begin
               // overflow bits start the next word.
               out_valid  <= 1'b1;
               acc        <= wide[WORD_W-1:0];
               acc_n      <= total - huf_sym_pkg::nbits_t'(WORD_W);
               flush_pend <= lk_last && (total != huf_sym_pkg::nbits_t'(WORD_W));
            end else if (lk_last) begin
               out_valid <= 1'b1;
               acc       <= '0;
               acc_n     <= '0;
            end else begin
               acc   <= wide[ACC_W-1:WORD_W];
               acc_n <= total;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sq_pop) begin
         lk_last <= sq_head_last;
      end
      if (flush_now) begin
         out_data  <= acc;
         out_nbits <= acc_n;
         out_last  <= 1'b1;
      end else if (append && (word_full || lk_last)) begin
         out_data <= wide[ACC_W-1:WORD_W];
         if (word_full) begin
            out_nbits <= huf_sym_pkg::nbits_t'(WORD_W);
            out_last  <= lk_last && (total == huf_sym_pkg::nbits_t'(WORD_W));
         end else begin
            out_nbits <= total;
            out_last  <= 1'b1;
         end
      end
   end

endmodule

// ==== hw/huf_comp_lut.sv ====
// Huffman code table, one entry per symbol.
// Software loads code and length through the write port between blocks.
// The assembler reads through a registered port, data one cycle later.

module huf_comp_lut (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               lut_wr,
   input  huf_sym_pkg::sym_t  lut_addr,
   input  huf_sym_pkg::code_t lut_code,
   input  huf_sym_pkg::len_t  lut_len,
   input  logic               lut_rd,
   input  huf_sym_pkg::sym_t  lut_rd_sym,
   output huf_sym_pkg::code_t rd_code,
   output huf_sym_pkg::len_t  rd_len
);

   localparam int unsigned NUM_SYM = 1 << huf_sym_pkg::SYM_W;

   huf_sym_pkg::code_t code_mem [NUM_SYM];
   huf_sym_pkg::len_t  len_mem [NUM_SYM];

   // lengths clear to unloaded.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_SYM; i++) begin
            len_mem[i] <= '0;
         end
         rd_len <= '0;
      end else begin
         if (lut_wr) begin
            len_mem[lut_addr] <= lut_len;
         end
         if (lut_rd) begin
            rd_len <= len_mem[lut_rd_sym];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (lut_wr) begin
         code_mem[lut_addr] <= lut_code;
      end
      if (lut_rd) begin
         rd_code <= code_mem[lut_rd_sym];
      end
   end

endmodule

// ==== hw/huf_comp_sq.sv ====
// Symbol queue between intake and the symbol assembler.
// Holds symbol and last-flag pairs. Full and empty are registered and
// computed from the next pointer values, so a pushed entry is visible
// at the head one cycle later.

module huf_comp_sq #(
   parameter int unsigned SQ_DEPTH = 8
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              sq_push,
   input  huf_sym_pkg::sym_t sq_sym,
   input  logic              sq_last,
   input  logic              sq_pop,
   output logic              sq_full,
   output logic              sq_empty,
   output huf_sym_pkg::sym_t sq_head_sym,
   output logic              sq_head_last
);

   localparam int unsigned PTR_W = $clog2(SQ_DEPTH);

   huf_sym_pkg::sym_t sym_mem [SQ_DEPTH];
   logic              last_mem [SQ_DEPTH];

   // top bit is the wrap bit.
   logic [PTR_W:0] wr_ptr;
   logic [PTR_W:0] rd_ptr;
   logic [PTR_W:0] wr_ptr_nxt;
   logic [PTR_W:0] rd_ptr_nxt;
   logic           do_push;
   logic           do_pop;

   assign do_push    = sq_push && !sq_full;
   assign do_pop     = sq_pop && !sq_empty;
   assign wr_ptr_nxt = wr_ptr + {{PTR_W{1'b0}}, do_push};
   assign rd_ptr_nxt = rd_ptr + {{PTR_W{1'b0}}, do_pop};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         sq_full  <= 1'b0;
         sq_empty <= 1'b1;
      end else begin
         wr_ptr   <= wr_ptr_nxt;
         rd_ptr   <= rd_ptr_nxt;
         sq_full  <= (wr_ptr_nxt[PTR_W] != rd_ptr_nxt[PTR_W]) &&
                     (wr_ptr_nxt[PTR_W-1:0] == rd_ptr_nxt[PTR_W-1:0]);
         sq_empty <= (wr_ptr_nxt == rd_ptr_nxt);
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         sym_mem[wr_ptr[PTR_W-1:0]]  <= sq_sym;
         last_mem[wr_ptr[PTR_W-1:0]] <= sq_last;
      end
   end

   assign sq_head_sym  = sym_mem[rd_ptr[PTR_W-1:0]];
   assign sq_head_last = last_mem[rd_ptr[PTR_W-1:0]];

endmodule

// ==== hw/huf_comp_sm.sv ====
// Intake control of the Huffman encode path.
// Moves symbols from the input stream into the symbol queue in the
// transfer cycle, tracks block framing on in_last and latches memory
// errors into a sticky flag that stops intake until reset.

module huf_comp_sm #(
   parameter int unsigned SQ_DEPTH = 8
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              in_valid,
   input  huf_sym_pkg::sym_t in_sym,
   input  logic              in_last,
   input  logic              sq_full,
   input  logic              ecc_error,
   output logic              in_ready,
   output logic              sq_push,
   output huf_sym_pkg::sym_t sq_sym,
   output logic              sq_last,
   output logic              ecc_error_reg
);

   huf_ctl_pkg::sm_state_t state;
   huf_ctl_pkg::sm_state_t state_nxt;

   // queue pointers wrap on a power-of-two depth.
   if (SQ_DEPTH < 2 || (SQ_DEPTH & (SQ_DEPTH - 1)) != 0) begin : g_depth_chk
      $error("huf_comp_sm: SQ_DEPTH must be a power of two of at least 2");
   end

   // intake stops on a full queue or after an error.
   assign in_ready = !sq_full && (state != huf_ctl_pkg::HALT);
   assign sq_push  = in_valid && in_ready;
   assign sq_sym   = in_sym;
   assign sq_last  = in_last;

   always_comb begin
      state_nxt = state;
      case (state)
         huf_ctl_pkg::IDLE: begin
            if (sq_push && !in_last) begin
               state_nxt = huf_ctl_pkg::IN_BLOCK;
            end
         end
         huf_ctl_pkg::IN_BLOCK: begin
            if (sq_push && in_last) begin
               state_nxt = huf_ctl_pkg::IDLE;
            end
         end
         default: begin
            state_nxt = huf_ctl_pkg::HALT;
         end
      endcase
      if (ecc_error) begin
         state_nxt = huf_ctl_pkg::HALT;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state         <= huf_ctl_pkg::IDLE;
         ecc_error_reg <= 1'b0;
      end else begin
         state <= state_nxt;
         if (ecc_error) begin
            ecc_error_reg <= 1'b1;
         end
      end
   end

endmodule

// ==== hw/huf_ctl_pkg.sv ====
// Control side types of the Huffman encode path.
// Intake state encoding and the per-block statistic counters.
// Referenced by scoped name from the RTL and the testbench.

package huf_ctl_pkg;

   parameter int unsigned SYM_CNT_W = 16;
   parameter int unsigned BIT_CNT_W = 20;

   // intake states.
   typedef enum logic [1:0] {
      IDLE     = 2'd0,
      IN_BLOCK = 2'd1,
      HALT     = 2'd2
   } sm_state_t;

   // symbols in one block.
   typedef logic [SYM_CNT_W-1:0] sym_cnt_t;

   // code bits in one block.
   typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

endpackage

// ==== hw/huf_sym_pkg.sv ====
// Symbol side types of the Huffman encode path.
// Widths of symbols, codes, code lengths and packed output words.
// Referenced by scoped name from the RTL and the testbench.

package huf_sym_pkg;

   // symbol alphabet.
   parameter int unsigned SYM_W = 4;

   // longest code the table can hold.
   parameter int unsigned MAX_CODE_LEN = 12;

   // packed output word.
   parameter int unsigned WORD_W = 32;

   parameter int unsigned LEN_W   = 4;
   parameter int unsigned NBITS_W = 6;

   typedef logic [SYM_W-1:0] sym_t;

   // right-aligned code value.
   typedef logic [MAX_CODE_LEN-1:0] code_t;

   // 0 marks an unloaded entry.
   typedef logic [LEN_W-1:0] len_t;

   typedef logic [WORD_W-1:0] word_t;

   // valid bits in an output word, 1 to WORD_W.
   typedef logic [NBITS_W-1:0] nbits_t;

endpackage
